//--- calc_pkg.sv
`default_nettype none

package calc_pkg;

	//////////////////////////////////////////////////////////////////////
	// Vector widths
	//////////////////////////////////////////////////////////////////////

	// Register contents
	typedef logic [15:0] word_t;

	// Register index, low nibble plus one high bit
	typedef logic [4:0] addr_t;

	// One hex digit from the operator
	typedef logic [3:0] digit_t;

	typedef logic [3:0] shamt_t;

	// Sixteen ASCII characters, leftmost in the top byte
	typedef logic [127:0] line_t;

	//////////////////////////////////////////////////////////////////////
	// Opcodes and display layouts
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		OP_WRITE       = 3'd0,
		OP_READ        = 3'd1,
		OP_READ2       = 3'd2,
		OP_WRITE_READ  = 3'd3,
		OP_READ2_WRITE = 3'd4,
		OP_CMP         = 3'd5,
		OP_XOR         = 3'd6,
		OP_SHIFT       = 3'd7
	} opcode_e;

	// Address on line 1 with a word or a single bit on line 2,
	// or a word on each line
	typedef enum logic [1:0] {
		SHOW_ADDR_WORD = 2'd0,
		SHOW_WORD_WORD = 2'd1,
		SHOW_ADDR_BIT  = 2'd2
	} show_e;

	//////////////////////////////////////////////////////////////////////
	// Structs passed between blocks
	//////////////////////////////////////////////////////////////////////

	// One fully entered command
	typedef struct packed {
		opcode_e op;
		addr_t   addr_a;
		addr_t   addr_b;
		addr_t   addr_w;
		word_t   data;
		shamt_t  shamt;
	} cmd_t;

	// Address sits in the low 5 bits of head
	// Bit layout uses tail[0] only
	typedef struct packed {
		show_e show;
		word_t head;
		word_t tail;
	} result_t;

	typedef struct packed {
		line_t line1;
		line_t line2;
	} display_t;

endpackage

`default_nettype wire

//--- cmd_entry.sv
`default_nettype none

module cmd_entry (
	input  logic             clk,
	input  logic             rst,
	input  logic             op_load,
	input  logic             digit_valid,
	input  logic             abort,
	input  calc_pkg::digit_t digit,
	output calc_pkg::cmd_t   cmd,
	output logic             cmd_valid
);

	// Every opcode walks a subsequence of this slot order
	typedef enum logic [3:0] {
		F_A_LO  = 4'd0,
		F_A_HI  = 4'd1,
		F_B_LO  = 4'd2,
		F_B_HI  = 4'd3,
		F_W_LO  = 4'd4,
		F_W_HI  = 4'd5,
		F_D0    = 4'd6,
		F_D1    = 4'd7,
		F_D2    = 4'd8,
		F_D3    = 4'd9,
		F_SHAMT = 4'd10
	} field_e;

	calc_pkg::opcode_e op_q;
	calc_pkg::addr_t   addr_a;
	calc_pkg::addr_t   addr_b;
	calc_pkg::addr_t   addr_w;
	calc_pkg::word_t   data;
	calc_pkg::shamt_t  shamt;
	logic [3:0]        cnt;
	logic [3:0]        last_cnt;
	field_e            field;
	logic              take;

	// op_load and abort win over a digit in the same cycle
	assign take = digit_valid && !op_load && !abort;

	// Digits per opcode, minus one
	always_comb begin
		case (op_q)
			calc_pkg::OP_WRITE:       last_cnt = 4'd5;
			calc_pkg::OP_READ:        last_cnt = 4'd1;
			calc_pkg::OP_READ2:       last_cnt = 4'd3;
			calc_pkg::OP_WRITE_READ:  last_cnt = 4'd7;
			calc_pkg::OP_READ2_WRITE: last_cnt = 4'd9;
			calc_pkg::OP_SHIFT:       last_cnt = 4'd4;
			default:                  last_cnt = 4'd5;
		endcase
	end

	// Slot for the current digit
	always_comb begin
		case (op_q)
			calc_pkg::OP_WRITE: field = field_e'(cnt + 4'd4);
			calc_pkg::OP_WRITE_READ: begin
				if (cnt < 4'd2)
					field = field_e'(cnt);
				else
					field = field_e'(cnt + 4'd2);
			end
			calc_pkg::OP_SHIFT: begin
				if (cnt < 4'd2)
					field = field_e'(cnt);
				else if (cnt < 4'd4)
					field = field_e'(cnt + 4'd2);
				else
					field = F_SHAMT;
			end
			default: field = field_e'(cnt);
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			op_q      <= calc_pkg::OP_WRITE;
			cnt       <= '0;
			cmd_valid <= 1'b0;
		end else begin
			cmd_valid <= 1'b0;
			if (op_load) begin
				op_q <= calc_pkg::opcode_e'(digit[2:0]);
				cnt  <= '0;
			end else if (abort) begin
				cnt <= '0;
			end else if (digit_valid) begin
				if (cnt == last_cnt) begin
					// Opcode stays for the next command
					cnt       <= '0;
					cmd_valid <= 1'b1;
				end else begin
					cnt <= cnt + 4'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			case (field)
				F_A_LO:  addr_a[3:0] <= digit;
				F_A_HI:  addr_a[4]   <= digit[0];
				F_B_LO:  addr_b[3:0] <= digit;
				F_B_HI:  addr_b[4]   <= digit[0];
				F_W_LO:  addr_w[3:0] <= digit;
				F_W_HI:  addr_w[4]   <= digit[0];
				F_D0:    data[3:0]   <= digit;
				F_D1:    data[7:4]   <= digit;
				F_D2:    data[11:8]  <= digit;
				F_D3:    data[15:12] <= digit;
				F_SHAMT: shamt       <= digit;
				default: ;
			endcase
		end
	end

	assign cmd = '{
		op:     op_q,
		addr_a: addr_a,
		addr_b: addr_b,
		addr_w: addr_w,
		data:   data,
		shamt:  shamt
	};

endmodule

`default_nettype wire

//--- reg_file.sv
`default_nettype none

module reg_file (
	input  logic            clk,
	input  logic            rst,
	input  calc_pkg::addr_t rd_addr_a,
	input  calc_pkg::addr_t rd_addr_b,
	output calc_pkg::word_t rd_data_a,
	output calc_pkg::word_t rd_data_b,
	input  logic            wr_en,
	input  calc_pkg::addr_t wr_addr,
	input  calc_pkg::word_t wr_data
);

	calc_pkg::word_t regs [32];

	// Write-first, a same-cycle write is seen by the read
	function automatic calc_pkg::word_t read_port(input calc_pkg::addr_t addr);
		if (wr_en && wr_addr == addr)
			return wr_data;
		return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	always_ff @(posedge clk) begin
		rd_data_a <= read_port(rd_addr_a);
		rd_data_b <= read_port(rd_addr_b);
	end

endmodule

`default_nettype wire

//--- op_exec.sv
`default_nettype none

module op_exec (
	input  logic              clk,
	input  logic              rst,
	input  calc_pkg::cmd_t    cmd,
	input  logic              cmd_valid,
	output calc_pkg::addr_t   rd_addr_a,
	output calc_pkg::addr_t   rd_addr_b,
	input  calc_pkg::word_t   rd_data_a,
	input  calc_pkg::word_t   rd_data_b,
	output logic              wr_en,
	output calc_pkg::addr_t   wr_addr,
	output calc_pkg::word_t   wr_data,
	output calc_pkg::result_t res,
	output logic              res_valid
);

	calc_pkg::cmd_t    s1_cmd;
	logic              s1_valid;
	calc_pkg::cmd_t    s2_cmd;
	logic              s2_valid;
	calc_pkg::word_t   s2_a;
	calc_pkg::word_t   s2_b;
	calc_pkg::word_t   value;
	logic              writes;
	calc_pkg::result_t next_res;

	//////////////////////////////////////////////////////////////////////
	// Stage 1 and 2: read issue, operand capture
	//////////////////////////////////////////////////////////////////////

	// Reads go out in the cycle the command arrives
	assign rd_addr_a = cmd.addr_a;
	assign rd_addr_b = cmd.addr_b;

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid  <= 1'b0;
			s2_valid  <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			s1_valid  <= cmd_valid;
			s2_valid  <= s1_valid;
			res_valid <= s2_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_valid)
			s1_cmd <= cmd;
		if (s1_valid) begin
			s2_cmd <= s1_cmd;
			s2_a   <= rd_data_a;
			s2_b   <= rd_data_b;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Stage 3: compute, write back, result
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (s2_cmd.op)
			calc_pkg::OP_CMP:   value = calc_pkg::word_t'($signed(s2_a) < $signed(s2_b));
			calc_pkg::OP_XOR:   value = s2_a ^ s2_b;
			calc_pkg::OP_SHIFT: value = calc_pkg::word_t'($signed(s2_a) >>> s2_cmd.shamt);
			default:            value = s2_cmd.data;
		endcase
	end

	always_comb begin
		case (s2_cmd.op)
			calc_pkg::OP_READ,
			calc_pkg::OP_READ2: writes = 1'b0;
			default:            writes = 1'b1;
		endcase
	end

	assign wr_en   = s2_valid && writes;
	assign wr_addr = s2_cmd.addr_w;
	assign wr_data = value;

	// Default is destination address with the computed word
	always_comb begin
		next_res.show = calc_pkg::SHOW_ADDR_WORD;
		next_res.head = calc_pkg::word_t'(s2_cmd.addr_w);
		next_res.tail = value;
		case (s2_cmd.op)
			calc_pkg::OP_READ,
			calc_pkg::OP_WRITE_READ: begin
				next_res.head = calc_pkg::word_t'(s2_cmd.addr_a);
				next_res.tail = s2_a;
			end
			calc_pkg::OP_READ2,
			calc_pkg::OP_READ2_WRITE: begin
				next_res.show = calc_pkg::SHOW_WORD_WORD;
				next_res.head = s2_a;
				next_res.tail = s2_b;
			end
			calc_pkg::OP_CMP: next_res.show = calc_pkg::SHOW_ADDR_BIT;
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (s2_valid)
			res <= next_res;
	end

endmodule

`default_nettype wire

//--- line_formatter.sv
`default_nettype none

module line_formatter (
	input  logic               clk,
	input  logic               rst,
	input  calc_pkg::result_t  res,
	input  logic               res_valid,
	output calc_pkg::display_t disp,
	output logic               disp_valid
);

	localparam logic [7:0] CH_ZERO  = 8'h30;
	localparam logic [7:0] CH_ONE   = 8'h31;
	localparam logic [7:0] CH_SPACE = 8'h20;

	calc_pkg::display_t next_disp;

	// Low width bits of value, MSB leftmost, padded with spaces
	function automatic calc_pkg::line_t render(input calc_pkg::word_t value, input int width);
		calc_pkg::line_t text;
		for (int i = 0; i < 16; i++) begin
			if (i >= width)
				text[127 - 8*i -: 8] = CH_SPACE;
			else if (value[width - 1 - i])
				text[127 - 8*i -: 8] = CH_ONE;
			else
				text[127 - 8*i -: 8] = CH_ZERO;
		end
		return text;
	endfunction

	always_comb begin
		case (res.show)
			calc_pkg::SHOW_WORD_WORD: begin
				next_disp.line1 = render(res.head, 16);
				next_disp.line2 = render(res.tail, 16);
			end
			calc_pkg::SHOW_ADDR_BIT: begin
				next_disp.line1 = render(res.head, 5);
				next_disp.line2 = render(res.tail, 1);
			end
			default: begin
				next_disp.line1 = render(res.head, 5);
				next_disp.line2 = render(res.tail, 16);
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			disp_valid <= 1'b0;
		else
			disp_valid <= res_valid;
	end

	// Lines hold until the next result
	always_ff @(posedge clk) begin
		if (res_valid)
			disp <= next_disp;
	end

endmodule

`default_nettype wire

//--- reg_calc_top.sv
`default_nettype none

module reg_calc_top (
	input  logic               clk,
	input  logic               rst,
	input  logic               op_load,
	input  logic               digit_valid,
	input  logic               abort,
	input  calc_pkg::digit_t   digit,
	output calc_pkg::display_t disp,
	output logic               disp_valid
);

	calc_pkg::cmd_t    cmd;
	logic              cmd_valid;
	calc_pkg::addr_t   rd_addr_a;
	calc_pkg::addr_t   rd_addr_b;
	calc_pkg::word_t   rd_data_a;
	calc_pkg::word_t   rd_data_b;
	logic              wr_en;
	calc_pkg::addr_t   wr_addr;
	calc_pkg::word_t   wr_data;
	calc_pkg::result_t res;
	logic              res_valid;

	cmd_entry u_entry (
		.clk         (clk),
		.rst         (rst),
		.op_load     (op_load),
		.digit_valid (digit_valid),
		.abort       (abort),
		.digit       (digit),
		.cmd         (cmd),
		.cmd_valid   (cmd_valid)
	);

	reg_file u_regs (
		.clk       (clk),
		.rst       (rst),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data)
	);

	op_exec u_exec (
		.clk       (clk),
		.rst       (rst),
		.cmd       (cmd),
		.cmd_valid (cmd_valid),
		.rd_addr_a (rd_addr_a),
		.rd_addr_b (rd_addr_b),
		.rd_data_a (rd_data_a),
		.rd_data_b (rd_data_b),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.res       (res),
		.res_valid (res_valid)
	);

	line_formatter u_fmt (
		.clk        (clk),
		.rst        (rst),
		.res        (res),
		.res_valid  (res_valid),
		.disp       (disp),
		.disp_valid (disp_valid)
	);

endmodule

`default_nettype wire

//--- tb_clock.sv
`default_nettype none

module tb_clock (
	output logic clk,
	output logic rst
);

	timeunit 1ns;
	timeprecision 1ps;

	// 40 ns period
	localparam int HALF_PERIOD = 20;

	initial begin
		clk = 1'b0;
		forever #HALF_PERIOD clk = ~clk;
	end

	// High for three rising edges, released on a falling edge
	initial begin
		rst = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

`default_nettype wire

//--- tb_checker.sv
`default_nettype none

module tb_checker (
	input  logic               clk,
	input  logic               rst,
	input  calc_pkg::display_t disp,
	input  logic               disp_valid,
	input  logic               exp_valid,
	input  calc_pkg::display_t exp_disp,
	input  int                 exp_id,
	output int                 passes,
	output int                 fails,
	output int                 pending
);

	timeunit 1ns;
	timeprecision 1ps;

	// Expected lines, test number and the cycle of the final digit
	calc_pkg::display_t want_q [$];
	int                 id_q [$];
	int                 stamp_q [$];
	int                 cycle = 0;

	initial begin
		passes  = 0;
		fails   = 0;
		pending = 0;
	end

	always @(posedge clk) begin : compare
		calc_pkg::display_t want;
		int                 id;
		int                 lat;
		cycle++;
		if (exp_valid) begin
			want_q.push_back(exp_disp);
			id_q.push_back(exp_id);
			stamp_q.push_back(cycle);
		end
		if (!rst && $isunknown(disp_valid)) begin
			fails++;
			$display("disp_valid is unknown at %0d ns although reset is released", $time);
		end else if (!rst && disp_valid) begin
			if (want_q.size() == 0) begin
				fails++;
				$display("Unexpected display at %0d ns with no command waiting for one", $time);
			end else begin
				want = want_q.pop_front();
				id   = id_q.pop_front();
				lat  = cycle - stamp_q.pop_front();
				if (disp !== want) begin
					fails++;
					$display("[FAIL] t=%0d ns test %0d: got \"%s\" / \"%s\", expected \"%s\" / \"%s\"",
						$time, id, disp.line1, disp.line2, want.line1, want.line2);
				end else if (lat != 5) begin
					fails++;
					$display("[FAIL] t=%0d ns test %0d: display %0d cycles after final digit, not 5",
						$time, id, lat);
				end else begin
					passes++;
					$display("[PASS] t=%0d ns test %0d: \"%s\" / \"%s\"",
						$time, id, disp.line1, disp.line2);
				end
			end
		end
		pending = want_q.size();
	end

endmodule

`default_nettype wire

//--- tb_reg_calc.sv
`default_nettype none

module tb_reg_calc;

	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		calc_pkg::opcode_e op;
		calc_pkg::addr_t   a;
		calc_pkg::addr_t   b;
		calc_pkg::addr_t   w;
		calc_pkg::word_t   data;
		logic              rnd;
		calc_pkg::shamt_t  shamt;
		logic [3:0]        gap;
		logic [3:0]        cut;
		logic              abrt;
	} row_t;

	logic               clk;
	logic               rst;
	logic               op_load;
	logic               digit_valid;
	logic               abort;
	calc_pkg::digit_t   digit;
	calc_pkg::display_t disp;
	logic               disp_valid;
	logic               exp_valid;
	calc_pkg::display_t exp_disp;
	int                 exp_id;
	int                 passes;
	int                 fails;
	int                 pending;
	row_t               rows [$];
	calc_pkg::word_t    shadow [32];
	calc_pkg::digit_t   seq [10];
	int                 seq_len;
	logic [31:0]        rng;
	int                 cycles = 0;
	int                 limit;

	tb_clock u_clock (
		.clk (clk),
		.rst (rst)
	);

	reg_calc_top UUT (
		.clk         (clk),
		.rst         (rst),
		.op_load     (op_load),
		.digit_valid (digit_valid),
		.abort       (abort),
		.digit       (digit),
		.disp        (disp),
		.disp_valid  (disp_valid)
	);

	tb_checker u_checker (
		.clk        (clk),
		.rst        (rst),
		.disp       (disp),
		.disp_valid (disp_valid),
		.exp_valid  (exp_valid),
		.exp_disp   (exp_disp),
		.exp_id     (exp_id),
		.passes     (passes),
		.fails      (fails),
		.pending    (pending)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Leftmost character holds the MSB of the shown bits
	function automatic calc_pkg::line_t bits_text(input calc_pkg::word_t v, input int n);
		calc_pkg::line_t t;
		t = {16{8'h20}};
		for (int k = 0; k < n; k++)
			t[127 - 8*k -: 8] = v[n - 1 - k] ? 8'h31 : 8'h30;
		return t;
	endfunction

	function automatic row_t mk(input calc_pkg::opcode_e op, input calc_pkg::addr_t a,
		input calc_pkg::addr_t b, input calc_pkg::addr_t w, input calc_pkg::word_t data,
		input logic rnd, input calc_pkg::shamt_t shamt, input int gap, input int cut,
		input logic abrt);
		return '{op, a, b, w, data, rnd, shamt, 4'(gap), 4'(cut), abrt};
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Stimulus table
	//////////////////////////////////////////////////////////////////////

	task automatic fill_table();
		// op, a, b, w, data, random data, shamt, gap, digits before cut, abort
		rows.push_back(mk(calc_pkg::OP_READ, 5'd5, 5'd0, 5'd0, 16'h0000, 0, 4'd0, 1, 0, 0));
		rows.push_back(mk(calc_pkg::OP_WRITE, 5'd0, 5'd0, 5'd3, 16'h1234, 0, 4'd0, 0, 0, 0));
		rows.push_back(mk(calc_pkg::OP_WRITE, 5'd0, 5'd0, 5'd20, 16'h0000, 1, 4'd0, 1, 0, 0));
		rows.push_back(mk(calc_pkg::OP_READ, 5'd3, 5'd0, 5'd0, 16'h0000, 0, 4'd0, 0, 0, 0));
		rows.push_back(mk(calc_pkg::OP_READ2, 5'd3, 5'd20, 5'd0, 16'h0000, 0, 4'd0, 2, 0, 0));
		rows.push_back(mk(calc_pkg::OP_WRITE_READ, 5'd3, 5'd0, 5'd3, 16'hbeef, 0, 4'd0, 0, 0, 0));
		rows.push_back(mk(calc_pkg::OP_READ, 5'd3, 5'd0, 5'd0, 16'h0000, 0, 4'd0, 0, 0, 0));
		rows.push_back(mk(calc_pkg::OP_READ2_WRITE, 5'd3, 5'd20, 5'd20, 16'h8001, 0, 4'd0, 1, 0, 0));
		rows.push_back(mk(calc_pkg::OP_READ, 5'd20, 5'd0, 5'd0, 16'h0000, 0, 4'd0, 0, 0, 0));
		rows.push_back(mk(calc_pkg::OP_WRITE, 5'd0, 5'd0, 5'd7, 16'hfff0, 0, 4'd0, 0, 0, 0));
		rows.push_back(mk(calc_pkg::OP_WRITE, 5'd0, 5'd0, 5'd8, 16'h0005, 0, 4'd0, 0, 0, 0));
		rows.push_back(mk(calc_pkg::OP_CMP, 5'd7, 5'd8, 5'd9, 16'h0000, 0, 4'd0, 1, 0, 0));
		rows.push_back(mk(calc_pkg::OP_CMP, 5'd8, 5'd7, 5'd10, 16'h0000, 0, 4'd0, 0, 0, 0));
		rows.push_back(mk(calc_pkg::OP_READ, 5'd9, 5'd0, 5'd0, 16'h0000, 0, 4'd0, 0, 0, 0));
		rows.push_back(mk(calc_pkg::OP_XOR, 5'd7, 5'd8, 5'd11, 16'h0000, 0, 4'd0, 0, 0, 0));
		rows.push_back(mk(calc_pkg::OP_READ, 5'd11, 5'd0, 5'd0, 16'h0000, 0, 4'd0, 0, 0, 0));
		rows.push_back(mk(calc_pkg::OP_SHIFT, 5'd7, 5'd0, 5'd12, 16'h0000, 0, 4'd3, 1, 0, 0));
		rows.push_back(mk(calc_pkg::OP_SHIFT, 5'd20, 5'd0, 5'd31, 16'h0000, 0, 4'd15, 0, 0, 0));
		rows.push_back(mk(calc_pkg::OP_READ, 5'd31, 5'd0, 5'd0, 16'h0000, 0, 4'd0, 0, 0, 0));
		rows.push_back(mk(calc_pkg::OP_WRITE, 5'd0, 5'd0, 5'd17, 16'h0000, 1, 4'd0, 0, 0, 0));
		rows.push_back(mk(calc_pkg::OP_READ, 5'd17, 5'd0, 5'd0, 16'h0000, 0, 4'd0, 0, 0, 0));
		// Broken off by abort and entered again, then broken off by a fresh op_load
		rows.push_back(mk(calc_pkg::OP_WRITE, 5'd0, 5'd0, 5'd2, 16'haaaa, 0, 4'd0, 1, 3, 1));
		rows.push_back(mk(calc_pkg::OP_READ, 5'd2, 5'd0, 5'd0, 16'h0000, 0, 4'd0, 0, 0, 0));
		rows.push_back(mk(calc_pkg::OP_XOR, 5'd3, 5'd20, 5'd4, 16'h0000, 0, 4'd0, 0, 2, 0));
		rows.push_back(mk(calc_pkg::OP_WRITE_READ, 5'd17, 5'd0, 5'd17, 16'h0000, 1, 4'd0, 0, 0, 0));
		rows.push_back(mk(calc_pkg::OP_READ, 5'd17, 5'd0, 5'd0, 16'h0000, 0, 4'd0, 0, 0, 0));
		rows.push_back(mk(calc_pkg::OP_CMP, 5'd12, 5'd7, 5'd13, 16'h0000, 0, 4'd0, 0, 0, 0));
		rows.push_back(mk(calc_pkg::OP_READ, 5'd4, 5'd0, 5'd0, 16'h0000, 0, 4'd0, 0, 0, 0));
	endtask

	task automatic push_digit(input calc_pkg::digit_t d);
		seq[seq_len] = d;
		seq_len++;
	endtask

	task automatic push_addr(input calc_pkg::addr_t x);
		push_digit(x[3:0]);
		push_digit({3'b000, x[4]});
	endtask

	task automatic build_digits(input row_t r);
		seq_len = 0;
		if (r.op != calc_pkg::OP_WRITE)
			push_addr(r.a);
		if (r.op == calc_pkg::OP_READ2 || r.op == calc_pkg::OP_READ2_WRITE ||
			r.op == calc_pkg::OP_CMP || r.op == calc_pkg::OP_XOR)
			push_addr(r.b);
		if (r.op != calc_pkg::OP_READ && r.op != calc_pkg::OP_READ2)
			push_addr(r.w);
		if (r.op == calc_pkg::OP_WRITE || r.op == calc_pkg::OP_WRITE_READ ||
			r.op == calc_pkg::OP_READ2_WRITE) begin
			for (int k = 0; k < 4; k++)
				push_digit(r.data[4*k +: 4]);
		end
		if (r.op == calc_pkg::OP_SHIFT)
			push_digit(r.shamt);
	endtask

	// Model reads see the registers from before this command's write
	task automatic model_row(input row_t r, output calc_pkg::display_t e);
		logic signed [15:0] va;
		logic signed [15:0] vb;
		calc_pkg::word_t    v;
		va = shadow[r.a];
		vb = shadow[r.b];
		v = r.data;
		e.line1 = bits_text({11'd0, r.w}, 5);
		case (r.op)
			calc_pkg::OP_READ, calc_pkg::OP_WRITE_READ: begin
				e.line1 = bits_text({11'd0, r.a}, 5);
				e.line2 = bits_text(va, 16);
			end
			calc_pkg::OP_READ2, calc_pkg::OP_READ2_WRITE: begin
				e.line1 = bits_text(va, 16);
				e.line2 = bits_text(vb, 16);
			end
			calc_pkg::OP_CMP: begin
				v = (va < vb) ? 16'd1 : 16'd0;
				e.line2 = bits_text(v, 1);
			end
			calc_pkg::OP_XOR: begin
				v = va ^ vb;
				e.line2 = bits_text(v, 16);
			end
			calc_pkg::OP_SHIFT: begin
				v = va >>> r.shamt;
				e.line2 = bits_text(v, 16);
			end
			default: e.line2 = bits_text(v, 16);
		endcase
		if (r.op != calc_pkg::OP_READ && r.op != calc_pkg::OP_READ2)
			shadow[r.w] = v;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Driving on the falling edge
	//////////////////////////////////////////////////////////////////////

	task automatic send_digits(input int n, input int gap, input logic last_expected,
		input calc_pkg::display_t e, input int id);
		for (int k = 0; k < n; k++) begin
			digit_valid = 1'b1;
			digit = seq[k];
			if (last_expected && k == n - 1) begin
				exp_valid = 1'b1;
				exp_disp = e;
				exp_id = id;
			end
			@(negedge clk);
			digit_valid = 1'b0;
			exp_valid = 1'b0;
			repeat (gap) @(negedge clk);
		end
	endtask

	task automatic apply_row(input row_t r, input int id);
		calc_pkg::display_t e;
		int                 n;
		build_digits(r);
		n = (r.cut != 0) ? int'(r.cut) : seq_len;
		if (r.cut == 0)
			model_row(r, e);
		op_load = 1'b1;
		digit = {1'b0, r.op};
		@(negedge clk);
		op_load = 1'b0;
		repeat (r.gap) @(negedge clk);
		send_digits(n, r.gap, r.cut == 0, e, id);
		if (r.abrt) begin
			abort = 1'b1;
			@(negedge clk);
			abort = 1'b0;
			repeat (r.gap) @(negedge clk);
			// Same command again on the kept opcode
			model_row(r, e);
			send_digits(seq_len, r.gap, 1'b1, e, id);
		end
	endtask

	task automatic finish_run(input logic timed_out);
		$display("Tests: %0d passed, %0d failed, %0d never displayed", passes, fails, pending);
		if (!timed_out && fails == 0 && pending == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit) begin
			$display("Timeout: run went past %0d cycles, %0d results outstanding", limit, pending);
			finish_run(1'b1);
		end
	end

	initial begin
		row_t r;
		int   id;
		int   n;
		op_load = 1'b0;
		digit_valid = 1'b0;
		abort = 1'b0;
		digit = '0;
		exp_valid = 1'b0;
		exp_disp = '0;
		exp_id = 0;
		rng = 32'd74961;
		for (int i = 0; i < 32; i++)
			shadow[i] = '0;
		fill_table();
		limit = 20;
		for (int i = 0; i < rows.size(); i++) begin
			build_digits(rows[i]);
			n = (rows[i].cut != 0) ? int'(rows[i].cut) : seq_len;
			limit += (1 + n) * (1 + rows[i].gap);
			if (rows[i].abrt)
				limit += (1 + seq_len) * (1 + rows[i].gap);
		end
		@(negedge rst);
		@(negedge clk);
		id = 1;
		for (int i = 0; i < rows.size(); i++) begin
			r = rows[i];
			if (r.rnd) begin
				rng = xorshift32(rng);
				r.data = rng[15:0];
			end
			apply_row(r, id);
			if (r.cut == 0 || r.abrt)
				id++;
		end
		while (pending != 0)
			@(negedge clk);
		// A stray strobe would show within the pipeline latency
		repeat (6) @(negedge clk);
		finish_run(1'b0);
	end

endmodule

`default_nettype wire

//--- src.f
calc_pkg.sv
cmd_entry.sv
reg_file.sv
op_exec.sv
line_formatter.sv
reg_calc_top.sv
tb_clock.sv
tb_checker.sv
tb_reg_calc.sv
